// File: design/cachePkg.sv
`default_nettype none

package cachePkg;

	// Cache geometry. Addresses count words, not bytes.
	localparam int addressWidth = 16;
	localparam int dataWidth = 32;
	localparam int offsetWidth = 2;
	localparam int indexWidth = 4;
	localparam int tagWidth = addressWidth - indexWidth - offsetWidth;
	localparam int ways = 2;
	localparam int lineWords = 1 << offsetWidth;
	localparam int sets = 1 << indexWidth; // Sets in each way.

	// Field positions in a word address: tag, index, offset from high to low.
	localparam int indexLsb = offsetWidth;
	localparam int tagLsb = offsetWidth + indexWidth;

	typedef logic [addressWidth-1:0] addressT;
	typedef logic [dataWidth-1:0] dataT;
	typedef logic [tagWidth-1:0] tagT;
	typedef logic [indexWidth-1:0] indexT;
	typedef logic [offsetWidth-1:0] offsetT;
	typedef logic [$clog2(ways)-1:0] wayT;

	localparam offsetT lastOffset = offsetT'(lineWords - 1); // Word that completes a fill.

	// No dirty state is needed since every write goes through to memory.
	typedef enum logic {
		invalid = 1'b0,
		valid = 1'b1
	} lineStateT;

	typedef enum logic [2:0] {
		idle,
		lookup,
		fill,
		writeThrough,
		respond
	} controllerStateT;

endpackage : cachePkg

`default_nettype wire

// File: design/setAssociativeCache.sv
`timescale 1ns/1ps
`default_nettype none

module setAssociativeCache (
	input logic clock,
	input logic rstN,
	input logic lookupEnable,
	input cachePkg::addressT lookupAddress,
	output logic lookupHit,
	output cachePkg::wayT lookupWay,
	output cachePkg::dataT lookupData,
	output cachePkg::wayT victimWay,
	input logic fillEnable,
	input cachePkg::wayT fillWay,
	input cachePkg::addressT fillAddress,
	input cachePkg::dataT fillData,
	input logic wordWriteEnable,
	input cachePkg::wayT wordWay,
	input cachePkg::addressT wordAddress,
	input cachePkg::dataT wordData,
	input logic probeEnable,
	input cachePkg::addressT probeAddress,
	output logic probeHit,
	output cachePkg::wayT probeWay,
	input logic invalidateEnable,
	input cachePkg::indexT invalidateIndex,
	input cachePkg::wayT invalidateWay
);
	import cachePkg::*;

	tagT tagArray [sets][ways];
	lineStateT stateArray [sets][ways];
	dataT dataArray [sets][ways][lineWords];
	wayT lruWay [sets]; // Way to replace next.

	tagT lookupTag;
	indexT lookupIndex;
	offsetT lookupOffset;
	tagT probeTag;
	indexT probeIndex;
	tagT fillTag;
	indexT fillIndex;
	offsetT fillOffset;
	indexT wordIndex;
	offsetT wordOffset;

	logic [ways-1:0] lookupMatch;
	logic [ways-1:0] probeMatch;
	wayT lookupMatchWay;
	wayT probeMatchWay;
	logic fillLast;

	assign lookupTag = lookupAddress[tagLsb +: tagWidth];
	assign lookupIndex = lookupAddress[indexLsb +: indexWidth];
	assign lookupOffset = lookupAddress[offsetWidth-1:0];
	assign probeTag = probeAddress[tagLsb +: tagWidth];
	assign probeIndex = probeAddress[indexLsb +: indexWidth];
	assign fillTag = fillAddress[tagLsb +: tagWidth];
	assign fillIndex = fillAddress[indexLsb +: indexWidth];
	assign fillOffset = fillAddress[offsetWidth-1:0];
	assign wordIndex = wordAddress[indexLsb +: indexWidth];
	assign wordOffset = wordAddress[offsetWidth-1:0];

	assign fillLast = fillEnable && fillOffset == lastOffset;

	// Both ports compare all ways of their set in parallel.
	always_comb begin
		lookupMatchWay = '0;
		probeMatchWay = '0;
		for (int w = 0; w < ways; w++) begin
			lookupMatch[w] = stateArray[lookupIndex][w] == valid
				&& tagArray[lookupIndex][w] == lookupTag;
			probeMatch[w] = stateArray[probeIndex][w] == valid
				&& tagArray[probeIndex][w] == probeTag;
			if (lookupMatch[w]) begin
				lookupMatchWay = wayT'(w);
			end
			if (probeMatch[w]) begin
				probeMatchWay = wayT'(w);
			end
		end
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			lookupHit <= 1'b0;
			lookupWay <= '0;
			victimWay <= '0;
			probeHit <= 1'b0;
			probeWay <= '0;
		end else begin
			probeHit <= probeEnable && |probeMatch; // One-cycle result strobe.
			if (probeEnable) begin
				probeWay <= probeMatchWay;
			end
			if (lookupEnable) begin
				lookupHit <= |lookupMatch;
				lookupWay <= lookupMatchWay;
				victimWay <= lruWay[lookupIndex];
			end
		end
	end

	// Line states and replacement order.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int s = 0; s < sets; s++) begin
				lruWay[s] <= '0;
				for (int w = 0; w < ways; w++) begin
					stateArray[s][w] <= invalid;
				end
			end
		end else begin
			if (lookupEnable && |lookupMatch) begin
				lruWay[lookupIndex] <= ~lookupMatchWay;
			end
			if (fillEnable && fillOffset == '0) begin
				stateArray[fillIndex][fillWay] <= invalid; // Old line is gone once overwritten.
			end
			if (fillLast) begin
				stateArray[fillIndex][fillWay] <= valid;
				lruWay[fillIndex] <= ~fillWay;
			end
			// Last assignment, so it beats a fill of the same line.
			if (invalidateEnable) begin
				stateArray[invalidateIndex][invalidateWay] <= invalid;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (lookupEnable) begin
			lookupData <= dataArray[lookupIndex][lookupMatchWay][lookupOffset];
		end
		if (fillEnable) begin
			dataArray[fillIndex][fillWay][fillOffset] <= fillData;
		end
		if (fillLast) begin
			tagArray[fillIndex][fillWay] <= fillTag;
		end
		if (wordWriteEnable) begin
			dataArray[wordIndex][wordWay][wordOffset] <= wordData;
		end
	end

endmodule : setAssociativeCache

`default_nettype wire

// File: design/writeThroughInvalidate.sv
`timescale 1ns/1ps
`default_nettype none

module writeThroughInvalidate (
	input logic clock,
	input logic rstN,
	input logic snoopWrite,
	input cachePkg::addressT snoopAddress,
	output logic probeEnable,
	output cachePkg::addressT probeAddress,
	input logic probeHit,
	input cachePkg::wayT probeWay,
	output logic invalidateEnable,
	output cachePkg::indexT invalidateIndex,
	output cachePkg::wayT invalidateWay
);
	import cachePkg::*;

	indexT heldIndex; // Set of the snooped write.

	// Another node wrote this word, so our copy of the line is stale.
	// Local writes go straight through and never need a writeback.
	assign probeEnable = snoopWrite;
	assign probeAddress = snoopAddress;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			heldIndex <= '0;
		end else if (snoopWrite) begin
			heldIndex <= snoopAddress[indexLsb +: indexWidth];
		end
	end

	// The probe hit strobe drops the matching line in the second cycle.
	assign invalidateEnable = probeHit;
	assign invalidateIndex = heldIndex;
	assign invalidateWay = probeWay;

endmodule : writeThroughInvalidate

`default_nettype wire

// File: design/cpuController.sv
`timescale 1ns/1ps
`default_nettype none

module cpuController (
	input logic clock,
	input logic rstN,
	input logic cpuReq,
	input logic cpuWrite,
	input cachePkg::addressT cpuAddress,
	input cachePkg::dataT cpuWriteData,
	output logic cpuDone,
	output cachePkg::dataT cpuReadData,
	output logic memRead,
	output logic memWrite,
	output cachePkg::addressT memAddress,
	output cachePkg::dataT memWriteData,
	input logic memDone,
	input cachePkg::dataT memReadData,
	output logic lookupEnable,
	output cachePkg::addressT lookupAddress,
	input logic lookupHit,
	input cachePkg::wayT lookupWay,
	input cachePkg::dataT lookupData,
	input cachePkg::wayT victimWay,
	output logic fillEnable,
	output cachePkg::wayT fillWay,
	output cachePkg::addressT fillAddress,
	output cachePkg::dataT fillData,
	output logic wordWriteEnable,
	output cachePkg::wayT wordWay,
	output cachePkg::addressT wordAddress,
	output cachePkg::dataT wordData
);
	import cachePkg::*;

	controllerStateT state;
	logic reqWrite;
	logic writeHit; // Write target is resident.
	offsetT fillOffset;
	addressT reqAddress;
	offsetT reqOffset;
	dataT reqData;
	dataT readData;

	assign reqOffset = reqAddress[offsetWidth-1:0];

	// The lookup starts in the request cycle, straight from the CPU.
	assign lookupEnable = state == idle && cpuReq;
	assign lookupAddress = cpuAddress;

	assign fillEnable = state == fill && memDone;
	assign fillAddress = {reqAddress[addressWidth-1:offsetWidth], fillOffset};
	assign fillData = memReadData;

	assign wordWriteEnable = state == writeThrough && memDone && writeHit;
	assign wordAddress = reqAddress;
	assign wordData = reqData;

	assign memAddress = (state == fill) ? fillAddress : reqAddress;
	assign memWriteData = reqData;

	assign cpuDone = state == respond;
	assign cpuReadData = readData;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state <= idle;
			reqWrite <= 1'b0;
			writeHit <= 1'b0;
			fillOffset <= '0;
			memRead <= 1'b0;
			memWrite <= 1'b0;
		end else begin
			memRead <= 1'b0; // Memory strobes last one cycle.
			memWrite <= 1'b0;
			case (state)
				idle: begin
					if (cpuReq) begin
						reqWrite <= cpuWrite;
						state <= lookup;
					end
				end
				lookup: begin
					writeHit <= lookupHit;
					if (reqWrite) begin
						memWrite <= 1'b1;
						state <= writeThrough;
					end else if (lookupHit) begin
						state <= respond;
					end else begin
						fillOffset <= '0;
						memRead <= 1'b1;
						state <= fill;
					end
				end
				fill: begin
					if (memDone) begin
						if (fillOffset == lastOffset) begin
							state <= respond;
						end else begin
							fillOffset <= fillOffset + 1'b1;
							memRead <= 1'b1;
						end
					end
				end
				writeThrough: begin
					if (memDone) begin
						state <= respond;
					end
				end
				respond: state <= idle;
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (lookupEnable) begin
			reqAddress <= cpuAddress;
			reqData <= cpuWriteData;
		end
		if (state == lookup) begin
			readData <= lookupData;
			fillWay <= victimWay;
			wordWay <= lookupWay;
		end
		if (fillEnable && fillOffset == reqOffset) begin
			readData <= memReadData; // Requested word, caught on the way in.
		end
	end

endmodule : cpuController

`default_nettype wire

// File: design/cacheNode.sv
`timescale 1ns/1ps
`default_nettype none

module cacheNode (
	input logic clock,
	input logic rstN,
	input logic cpuReq,
	input logic cpuWrite,
	input cachePkg::addressT cpuAddress,
	input cachePkg::dataT cpuWriteData,
	output logic cpuDone,
	output cachePkg::dataT cpuReadData,
	output logic memRead,
	output logic memWrite,
	output cachePkg::addressT memAddress,
	output cachePkg::dataT memWriteData,
	input logic memDone,
	input cachePkg::dataT memReadData,
	input logic snoopWrite,
	input cachePkg::addressT snoopAddress
);
	import cachePkg::*;

	// Controller to cache.
	logic lookupEnable;
	addressT lookupAddress;
	logic lookupHit;
	wayT lookupWay;
	dataT lookupData;
	wayT victimWay;
	logic fillEnable;
	wayT fillWay;
	addressT fillAddress;
	dataT fillData;
	logic wordWriteEnable;
	wayT wordWay;
	addressT wordAddress;
	dataT wordData;

	// Snooping unit to cache.
	logic probeEnable;
	addressT probeAddress;
	logic probeHit;
	wayT probeWay;
	logic invalidateEnable;
	indexT invalidateIndex;
	wayT invalidateWay;

	cpuController controller (.*);

	setAssociativeCache cache (.*);

	writeThroughInvalidate snoop (.*);

endmodule : cacheNode

`default_nettype wire

// File: test/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
	output logic clock
);
	localparam time halfPeriod = 4; // 8 ns period.

	initial begin
		clock = 1'b0;
		forever begin
			#(halfPeriod) clock = ~clock;
		end
	end

endmodule : clockGen

`default_nettype wire

// File: test/tb.sv
`timescale 1ns/1ps
`default_nettype none

module tb;
	import cachePkg::*;

	localparam int resetCycles = 16;
	localparam int directedOps = 19;
	localparam int randomOps = 400;
	localparam int cyclesPerOp = 60;
	localparam int timeoutCycles = cyclesPerOp * (directedOps + randomOps) + resetCycles;

	logic clock;
	logic rstN;
	logic cpuReq;
	logic cpuWrite;
	addressT cpuAddress;
	dataT cpuWriteData;
	logic cpuDone;
	dataT cpuReadData;
	logic memRead;
	logic memWrite;
	addressT memAddress;
	dataT memWriteData;
	logic memDone;
	dataT memReadData;
	logic snoopWrite;
	addressT snoopAddress;

	dataT shadowMem [0:(1 << addressWidth) - 1]; // Memory as the whole bus sees it.
	tagT modelTag [sets][ways];
	logic modelValid [sets][ways];
	wayT modelLru [sets];

	logic opActive = 1'b0;
	logic opWrite = 1'b0;
	addressT opAddress = '0;
	dataT opData = '0;
	int opReadBase = 0;
	int readStrobes = 0; // Counted by the memory model only.
	int writeStrobes = 0;
	int cycleCount = 0;
	addressT accessAddress;
	int accessDelay;

	clockGen clocker (.clock(clock));

	cacheNode i_dut (.*);

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic checkData(input string name, input dataT actual, input dataT expected);
		if (actual !== expected) begin
			failRun($sformatf("error: %s = 0x%08h, expected 0x%08h", name, actual, expected));
		end
	endtask

	task automatic checkAddress(input string name, input addressT actual, input addressT expected);
		if (actual !== expected) begin
			failRun($sformatf("error: %s = 0x%04h, expected 0x%04h", name, actual, expected));
		end
	endtask

	task automatic checkFlag(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			failRun($sformatf("error: %s = 0x%0h, expected 0x%0h", name, actual, expected));
		end
	endtask

	function automatic dataT fillPattern(input addressT address);
		return {~address, address ^ 16'h3c5a};
	endfunction

	// Reference result of a read.
	function automatic dataT expectedRead(input addressT address);
		return shadowMem[address];
	endfunction

	function automatic logic predictHit(input addressT address, output wayT way);
		indexT index;
		tagT tag;
		logic hit;
		index = address[indexLsb +: indexWidth];
		tag = address[tagLsb +: tagWidth];
		hit = 1'b0;
		way = '0;
		for (int w = 0; w < ways; w++) begin
			if (modelValid[index][w] && modelTag[index][w] == tag) begin
				hit = 1'b1;
				way = wayT'(w);
			end
		end
		return hit;
	endfunction

	// Eight tags over four sets, so lines keep getting evicted.
	function automatic addressT randomAddress();
		return addressT'(($urandom_range(0, 7) << tagLsb) | ($urandom_range(0, 3) << indexLsb)
			| $urandom_range(0, lineWords - 1));
	endfunction

	// Memory model that answers each strobe after 1 to 4 cycles.
	initial begin
		memDone <= 1'b0;
		memReadData <= '0;
		forever begin
			@(negedge clock);
			if (memRead) begin
				if (opWrite) failRun("memRead was raised during a write request");
				if (readStrobes - opReadBase >= lineWords) begin
					failRun("more than four memRead strobes for one read miss");
				end
				checkAddress("memAddress", memAddress,
					{opAddress[addressWidth-1:offsetWidth], offsetT'(readStrobes - opReadBase)});
				readStrobes++;
			end
			if (memWrite) begin
				if (!opWrite) failRun("memWrite was raised during a read request");
				checkAddress("memAddress", memAddress, opAddress);
				checkData("memWriteData", memWriteData, opData);
				writeStrobes++;
			end
			if (memRead || memWrite) begin
				accessAddress = memAddress;
				accessDelay = $urandom_range(1, 4);
				repeat (accessDelay) @(posedge clock);
				memDone <= 1'b1;
				memReadData <= shadowMem[accessAddress];
				@(posedge clock);
				memDone <= 1'b0;
				memReadData <= '0;
			end
		end
	end

	// Nothing may move while no request is open.
	always @(negedge clock) begin
		if (!opActive) begin
			checkFlag("cpuDone", cpuDone, 1'b0);
			checkFlag("memRead", memRead, 1'b0);
			checkFlag("memWrite", memWrite, 1'b0);
		end
	end

	always @(posedge clock) begin
		cycleCount++;
		if (cycleCount >= timeoutCycles) begin
			failRun($sformatf("timeout after %0d cycles without reaching the end of the test",
				cycleCount));
		end
	end

	task automatic cpuAccess(input logic write, input addressT address, input dataT data);
		logic predictedHit;
		wayT hitWay;
		wayT victim;
		indexT index;
		int writesBefore;
		int reads;
		int writes;
		int cycles;
		predictedHit = predictHit(address, hitWay);
		index = address[indexLsb +: indexWidth];
		@(posedge clock);
		opActive = 1'b1;
		opWrite = write;
		opAddress = address;
		opData = data;
		opReadBase = readStrobes;
		writesBefore = writeStrobes;
		cpuReq <= 1'b1;
		cpuWrite <= write;
		cpuAddress <= address;
		cpuWriteData <= data;
		@(negedge clock);
		checkFlag("cpuDone", cpuDone, 1'b0);
		cycles = 0;
		@(posedge clock);
		cpuReq <= 1'b0;
		do begin
			@(negedge clock);
			cycles++;
		end while (!cpuDone);
		reads = readStrobes - opReadBase;
		writes = writeStrobes - writesBefore;
		if (write) begin
			if (writes != 1) failRun($sformatf("write to 0x%04h issued %0d memWrite strobes",
				address, writes));
			shadowMem[address] = data;
			if (predictedHit) modelLru[index] = ~hitWay;
		end else begin
			checkFlag("readHit", reads == 0, predictedHit);
			if (predictedHit && cycles != 2) begin
				failRun($sformatf("read hit at 0x%04h took %0d cycles instead of 2",
					address, cycles));
			end
			if (!predictedHit && reads != lineWords) begin
				failRun($sformatf("read miss at 0x%04h issued %0d memRead strobes",
					address, reads));
			end
			checkData("cpuReadData", cpuReadData, expectedRead(address));
			if (predictedHit) begin
				modelLru[index] = ~hitWay;
			end else begin
				victim = modelLru[index];
				modelTag[index][victim] = address[tagLsb +: tagWidth];
				modelValid[index][victim] = 1'b1;
				modelLru[index] = ~victim;
			end
		end
		@(posedge clock);
		opActive = 1'b0;
	endtask

	// Another node writes the word on the bus.
	task automatic remoteWrite(input addressT address, input dataT data);
		logic hit;
		wayT way;
		hit = predictHit(address, way);
		@(posedge clock);
		snoopWrite <= 1'b1;
		snoopAddress <= address;
		@(posedge clock);
		snoopWrite <= 1'b0;
		shadowMem[address] = data;
		if (hit) modelValid[address[indexLsb +: indexWidth]][way] = 1'b0;
		repeat (2) @(posedge clock);
	endtask

	task automatic directedSequence();
		cpuAccess(1'b0, 16'h0010, '0); // Fill set 4, then hits in the same line.
		cpuAccess(1'b0, 16'h0013, '0);
		cpuAccess(1'b0, 16'h0010, '0);
		cpuAccess(1'b1, 16'h0012, 32'hdeadbeef); // Write hit.
		cpuAccess(1'b0, 16'h0012, '0);
		cpuAccess(1'b1, 16'h0104, 32'h0badf00d); // Write miss that allocates nothing.
		cpuAccess(1'b0, 16'h0104, '0);
		// Three tags in set 4.
		cpuAccess(1'b0, 16'h0050, '0);
		cpuAccess(1'b0, 16'h0011, '0);
		cpuAccess(1'b0, 16'h0090, '0);
		cpuAccess(1'b0, 16'h0051, '0);
		cpuAccess(1'b0, 16'h0092, '0);
		cpuAccess(1'b0, 16'h0200, '0);
		cpuAccess(1'b0, 16'h0201, '0);
		remoteWrite(16'h0202, 32'h5eed0202); // Resident line.
		cpuAccess(1'b0, 16'h0202, '0);
		cpuAccess(1'b0, 16'h0200, '0);
		remoteWrite(16'h0300, 32'h5eed0300);
		cpuAccess(1'b0, 16'h0300, '0);
	endtask

	task automatic randomMix();
		int kind;
		addressT address;
		for (int i = 0; i < randomOps; i++) begin
			kind = $urandom_range(0, 9);
			address = randomAddress();
			if (kind < 5) begin
				cpuAccess(1'b0, address, '0);
			end else if (kind < 8) begin
				cpuAccess(1'b1, address, dataT'($urandom));
			end else begin
				remoteWrite(address, dataT'($urandom));
			end
		end
	endtask

	initial begin
		void'($urandom(32'hcc2515e7));
		rstN <= 1'b0;
		cpuReq <= 1'b0;
		cpuWrite <= 1'b0;
		cpuAddress <= '0;
		cpuWriteData <= '0;
		snoopWrite <= 1'b0;
		snoopAddress <= '0;
		for (int a = 0; a < (1 << addressWidth); a++) begin
			shadowMem[addressT'(a)] = fillPattern(addressT'(a));
		end
		for (int s = 0; s < sets; s++) begin
			modelLru[s] = '0;
			for (int w = 0; w < ways; w++) begin
				modelTag[s][w] = '0;
				modelValid[s][w] = 1'b0;
			end
		end
		repeat (resetCycles) @(posedge clock);
		rstN <= 1'b1;
		repeat (4) @(posedge clock); // Idle outputs are watched by the monitor.
		directedSequence();
		randomMix();
		repeat (4) @(posedge clock);
		$display("Verification passed");
		$finish;
	end

endmodule : tb

`default_nettype wire

// File: flist.f
design/cachePkg.sv
design/setAssociativeCache.sv
design/writeThroughInvalidate.sv
design/cpuController.sv
design/cacheNode.sv
test/clockGen.sv
test/tb.sv

// File: Makefile
TOOL = verilator
FLAGS = --binary --timing
LINT_FLAGS = --lint-only --timing -Wall
TOP = tb
FILELIST = flist.f
BUILD_DIR = obj_dir
PASS_TEXT = Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
